// ==== sim.f ====
+incdir+include
rtl/regfile_addr_pkg.sv
rtl/regfile_data_pkg.sv
rtl/init_sweep.sv
rtl/reg_tile.sv
rtl/const_operand_latch.sv
rtl/operand_select.sv
rtl/regfile_top.sv
test/regfile_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the register file testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module regfile_tb -f sim.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vregfile_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== test/regfile_tb.sv ====
// register file testbench
`timescale 1ns/1ps
`include "regfile_defs.svh"

module regfile_tb;

  import regfile_addr_pkg::*;
  import regfile_data_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 4;
  localparam int ADDR_COUNT    = 1 << `REGFILE_ADDR_WIDTH;
  localparam int RAND_WRITES   = 40;
  localparam int CONST_READS   = 8;
  localparam int HOLD_ROUNDS   = 4;
  localparam int RETIRE_ROUNDS = 8;
  localparam int RETIRE_HOLD   = 3;
  // cycles per test in order, then a margin for the watchdog
  localparam int TEST_CYCLES = (RESET_CYCLES + `REGFILE_SWEEP_STEPS + 2 + 2 * ADDR_COUNT)
                             + (3 + 2 * RAND_WRITES + ADDR_COUNT) + 2 * CONST_READS
                             + 3 * HOLD_ROUNDS + RETIRE_ROUNDS * (2 + RETIRE_HOLD);
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 200;

  logic      clk, rst, read_en, retire_en, init_busy;
  logic      read0_const_en, read1_const_en, write0_en, write1_en;
  reg_addr_t read0_addr, read1_addr, retire_addr, write0_addr, write1_addr;
  reg_data_t write0_data, write1_data;
  operand_t  read0_const, read1_const, read0_data, read1_data, retire_data;

  reg_data_t   model [ADDR_COUNT];
  logic [31:0] lfsr_state;
  int          checks, errors, test_checks, test_errors;
  logic        chk_busy, chk_read0, chk_read1, chk_retire, exp_busy;
  operand_t    exp_read0, exp_read1, exp_retire;

  regfile_top UUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++)
    begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // expectations are armed on the falling edge, checked on the next rising edge
  always @(posedge clk)
  begin
    if (chk_busy)
      check_value("init_busy", 32'(init_busy), 32'(exp_busy));
    if (chk_read0)
      check_value("read0_data", read0_data, exp_read0);
    if (chk_read1)
      check_value("read1_data", read1_data, exp_read1);
    if (chk_retire)
      check_value("retire_data", retire_data, exp_retire);
    chk_busy   = 1'b0;
    chk_read0  = 1'b0;
    chk_read1  = 1'b0;
    chk_retire = 1'b0;
  end

  task automatic read_check(input reg_addr_t a0, input reg_addr_t a1, input reg_addr_t ar,
                            input logic c0_en, input operand_t c0,
                            input logic c1_en, input operand_t c1);
    read_en        = 1'b1;
    retire_en      = 1'b1;
    read0_addr     = a0;
    read1_addr     = a1;
    retire_addr    = ar;
    read0_const_en = c0_en;
    read0_const    = c0;
    read1_const_en = c1_en;
    read1_const    = c1;
    @(negedge clk);
    read_en        = 1'b0;
    retire_en      = 1'b0;
    read0_const_en = 1'b0;
    read1_const_en = 1'b0;
    exp_read0      = c0_en ? c0 : model[a0];
    exp_read1      = c1_en ? c1 : model[a1];
    exp_retire     = model[ar];
    chk_read0      = 1'b1;
    chk_read1      = 1'b1;
    chk_retire     = 1'b1;
    @(negedge clk);
  endtask

  task automatic write_pair(input reg_addr_t a0, input reg_data_t d0, input logic e0,
                            input reg_addr_t a1, input reg_data_t d1, input logic e1);
    write0_addr = a0;
    write0_data = d0;
    write0_en   = e0;
    write1_addr = a1;
    write1_data = d1;
    write1_en   = e1;
    @(negedge clk);
    write0_en = 1'b0;
    write1_en = 1'b0;
    if (e0)
      model[a0] = d0;
    // port 1 lands last on a shared address
    if (e1)
      model[a1] = d1;
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
             errors - test_errors);
    test_checks = checks;
    test_errors = errors;
  endtask

  initial
  begin
    reg_addr_t a0, a1, ar;
    reg_data_t d0, d1;
    lfsr_state     = 32'hf3eccffd;
    rst            = 1'b1;
    read_en        = 1'b0;
    retire_en      = 1'b0;
    read0_const_en = 1'b0;
    read1_const_en = 1'b0;
    write0_en      = 1'b0;
    write1_en      = 1'b0;
    read0_addr     = '0;
    read1_addr     = '0;
    retire_addr    = '0;
    write0_addr    = '0;
    write1_addr    = '0;
    read0_const    = '0;
    read1_const    = '0;
    write0_data    = '0;
    write1_data    = '0;
    checks         = 0;
    errors         = 0;
    test_checks    = 0;
    test_errors    = 0;
    chk_busy       = 1'b0;
    chk_read0      = 1'b0;
    chk_read1      = 1'b0;
    chk_retire     = 1'b0;
    exp_busy       = 1'b0;
    exp_read0      = '0;
    exp_read1      = '0;
    exp_retire     = '0;
    for (int a = 0; a < ADDR_COUNT; a++)
      model[a] = '0;

    @(negedge clk);
    for (int i = 1; i < RESET_CYCLES; i++)
    begin
      exp_busy = 1'b1;
      chk_busy = 1'b1;
      @(negedge clk);
    end
    rst = 1'b0;
    for (int i = 0; i < `REGFILE_SWEEP_STEPS; i++)
    begin
      exp_busy = 1'b1;
      chk_busy = 1'b1;
      // nothing captured yet so every port reads zero
      exp_read0  = '0;
      exp_read1  = '0;
      exp_retire = '0;
      chk_read0  = 1'b1;
      chk_read1  = 1'b1;
      chk_retire = 1'b1;
      // port 0 writes are ignored while the sweep runs
      write0_en   = 1'b1;
      write0_addr = reg_addr_t'(take_bits(7));
      write0_data = take_bits(32);
      @(negedge clk);
    end
    write0_en = 1'b0;
    exp_busy  = 1'b0;
    chk_busy  = 1'b1;
    @(negedge clk);
    for (int a = 0; a < ADDR_COUNT; a++)
      read_check(reg_addr_t'(a), reg_addr_t'(ADDR_COUNT - 1 - a), reg_addr_t'(a),
                 1'b0, '0, 1'b0, '0);
    end_test("reset sweep");

    a0 = reg_addr_t'(take_bits(7));
    d0 = take_bits(32);
    d1 = take_bits(32);
    write_pair(a0, d0, 1'b1, a0, d1, 1'b1);
    read_check(a0, a0, a0, 1'b0, '0, 1'b0, '0);
    for (int i = 0; i < RAND_WRITES; i++)
    begin
      a0 = reg_addr_t'(take_bits(7));
      a1 = (take_bits(1) != 0) ? a0 : reg_addr_t'(take_bits(7));
      d0 = take_bits(32);
      d1 = take_bits(32);
      write_pair(a0, d0, 1'b1, a1, d1, take_bits(1) != 0);
    end
    for (int a = 0; a < ADDR_COUNT / 2; a++)
      read_check(reg_addr_t'(a), reg_addr_t'(a + ADDR_COUNT / 2),
                 reg_addr_t'(ADDR_COUNT - 1 - a), 1'b0, '0, 1'b0, '0);
    end_test("random writes");

    for (int i = 0; i < CONST_READS; i++)
    begin
      a0 = reg_addr_t'(take_bits(7));
      a1 = reg_addr_t'(take_bits(7));
      ar = reg_addr_t'(take_bits(7));
      read_check(a0, a1, ar, i % 2 == 0, take_bits(32), i % 2 == 1, take_bits(32));
    end
    end_test("constant override");

    for (int i = 0; i < HOLD_ROUNDS; i++)
    begin
      a0 = reg_addr_t'(take_bits(7));
      a1 = reg_addr_t'(take_bits(7));
      read_en    = 1'b1;
      read0_addr = a0;
      read1_addr = a1;
      @(negedge clk);
      // new inputs are ignored while read_en stays low
      read_en    = 1'b0;
      read0_addr = ~a0;
      read1_addr = ~a1;
      exp_read0  = model[a0];
      exp_read1  = model[a1];
      chk_read0  = 1'b1;
      chk_read1  = 1'b1;
      write_pair(a0, take_bits(32), 1'b1, a1, take_bits(32), 1'b1);
      exp_read0 = model[a0];
      exp_read1 = model[a1];
      chk_read0 = 1'b1;
      chk_read1 = 1'b1;
      @(negedge clk);
    end
    end_test("held read address");

    for (int i = 0; i < RETIRE_ROUNDS; i++)
    begin
      ar = reg_addr_t'(take_bits(7));
      retire_en   = 1'b1;
      retire_addr = ar;
      @(negedge clk);
      retire_en = 1'b0;
      for (int j = 0; j <= RETIRE_HOLD; j++)
      begin
        retire_addr = reg_addr_t'(take_bits(7));
        exp_retire  = model[ar];
        chk_retire  = 1'b1;
        @(negedge clk);
      end
    end
    end_test("retire port");

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== rtl/regfile_top.sv ====
// tiled register file top
`timescale 1ns/1ps
`include "regfile_defs.svh"

module regfile_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          read_en,
  input  regfile_addr_pkg::reg_addr_t   read0_addr,
  input  regfile_addr_pkg::reg_addr_t   read1_addr,
  input  logic                          read0_const_en,
  input  regfile_data_pkg::operand_t    read0_const,
  input  logic                          read1_const_en,
  input  regfile_data_pkg::operand_t    read1_const,
  input  logic                          retire_en,
  input  regfile_addr_pkg::reg_addr_t   retire_addr,
  input  regfile_addr_pkg::reg_addr_t   write0_addr,
  input  regfile_data_pkg::reg_data_t   write0_data,
  input  logic                          write0_en,
  input  regfile_addr_pkg::reg_addr_t   write1_addr,
  input  regfile_data_pkg::reg_data_t   write1_data,
  input  logic                          write1_en,
  output regfile_data_pkg::operand_t    read0_data,
  output regfile_data_pkg::operand_t    read1_data,
  output regfile_data_pkg::operand_t    retire_data,
  output logic                          init_busy
);

  import regfile_addr_pkg::*;
  import regfile_data_pkg::*;

  row_idx_t  sweep_row;
  logic      sweep_bank;

  reg_data_t tile_read0_data  [`REGFILE_TILE_COUNT];
  reg_data_t tile_read1_data  [`REGFILE_TILE_COUNT];
  reg_data_t tile_retire_data [`REGFILE_TILE_COUNT];
  logic [`REGFILE_TILE_COUNT-1:0] tile_retire_hit;

  logic      read0_const_en_held;
  logic      read1_const_en_held;
  operand_t  read0_const_held;
  operand_t  read1_const_held;

  init_sweep u_init_sweep (
    .clk        (clk),
    .rst        (rst),
    .init_busy  (init_busy),
    .sweep_row  (sweep_row),
    .sweep_bank (sweep_bank)
  );

  for (genvar t = 0; t < `REGFILE_TILE_COUNT; t++)
  begin : g_tile
    reg_tile #(
      .TILE_INDEX (t)
    ) u_tile (
      .clk         (clk),
      .rst         (rst),
      .read_en     (read_en),
      .retire_en   (retire_en),
      .init_busy   (init_busy),
      .sweep_row   (sweep_row),
      .sweep_bank  (sweep_bank),
      .read0_addr  (read0_addr),
      .read1_addr  (read1_addr),
      .retire_addr (retire_addr),
      .write0_addr (write0_addr),
      .write0_data (write0_data),
      .write0_en   (write0_en),
      .write1_addr (write1_addr),
      .write1_data (write1_data),
      .write1_en   (write1_en),
      .read0_data  (tile_read0_data[t]),
      .read1_data  (tile_read1_data[t]),
      .retire_data (tile_retire_data[t]),
      .retire_hit  (tile_retire_hit[t])
    );
  end

  // constants are captured on the same read_en edge as the addresses
  const_operand_latch u_const_latch (
    .clk                 (clk),
    .rst                 (rst),
    .read_en             (read_en),
    .read0_const_en      (read0_const_en),
    .read1_const_en      (read1_const_en),
    .read0_const         (read0_const),
    .read1_const         (read1_const),
    .read0_const_en_held (read0_const_en_held),
    .read1_const_en_held (read1_const_en_held),
    .read0_const_held    (read0_const_held),
    .read1_const_held    (read1_const_held)
  );

  operand_select u_operand_select (
    .tile_read0_data     (tile_read0_data),
    .tile_read1_data     (tile_read1_data),
    .tile_retire_data    (tile_retire_data),
    .tile_retire_hit     (tile_retire_hit),
    .read0_const_en_held (read0_const_en_held),
    .read1_const_en_held (read1_const_en_held),
    .read0_const_held    (read0_const_held),
    .read1_const_held    (read1_const_held),
    .read0_data          (read0_data),
    .read1_data          (read1_data),
    .retire_data         (retire_data)
  );

endmodule

// ==== rtl/operand_select.sv ====
// operand merge and constant override
`timescale 1ns/1ps
`include "regfile_defs.svh"

module operand_select (
  input  regfile_data_pkg::reg_data_t   tile_read0_data  [`REGFILE_TILE_COUNT],
  input  regfile_data_pkg::reg_data_t   tile_read1_data  [`REGFILE_TILE_COUNT],
  input  regfile_data_pkg::reg_data_t   tile_retire_data [`REGFILE_TILE_COUNT],
  input  logic [`REGFILE_TILE_COUNT-1:0] tile_retire_hit,
  input  logic                          read0_const_en_held,
  input  logic                          read1_const_en_held,
  input  regfile_data_pkg::operand_t    read0_const_held,
  input  regfile_data_pkg::operand_t    read1_const_held,
  output regfile_data_pkg::operand_t    read0_data,
  output regfile_data_pkg::operand_t    read1_data,
  output regfile_data_pkg::operand_t    retire_data
);

  import regfile_data_pkg::*;

  reg_data_t merged0;
  reg_data_t merged1;
  reg_data_t retire_merged;

  // at most one tile has its hit set per port
  always_comb
  begin
    merged0       = '0;
    merged1       = '0;
    retire_merged = '0;
    for (int t = 0; t < `REGFILE_TILE_COUNT; t++)
    begin
      merged0 = merged0 | tile_read0_data[t];
      merged1 = merged1 | tile_read1_data[t];
      // retire words come ungated from the tiles
      retire_merged = retire_merged |
                      (tile_retire_data[t] & {`REGFILE_DATA_WIDTH{tile_retire_hit[t]}});
    end
  end

  assign read0_data  = read0_const_en_held ? read0_const_held : operand_t'(merged0);
  assign read1_data  = read1_const_en_held ? read1_const_held : operand_t'(merged1);
  assign retire_data = operand_t'(retire_merged);

endmodule

// ==== rtl/const_operand_latch.sv ====
// constant operand latch
`timescale 1ns/1ps
`include "regfile_defs.svh"

module const_operand_latch (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        read_en,
  input  logic                        read0_const_en,
  input  logic                        read1_const_en,
  input  regfile_data_pkg::operand_t  read0_const,
  input  regfile_data_pkg::operand_t  read1_const,
  output logic                        read0_const_en_held,
  output logic                        read1_const_en_held,
  output regfile_data_pkg::operand_t  read0_const_held,
  output regfile_data_pkg::operand_t  read1_const_held
);

  import regfile_data_pkg::*;

  // index is the read port
  logic [1:0] en_q;
  operand_t   value_q [2];

  always_ff @(posedge clk)
  begin
    if (rst)
      en_q <= '0;
    else if (read_en)
      en_q <= {read1_const_en, read0_const_en};
  end

  always_ff @(posedge clk)
  begin
    if (read_en)
    begin
      value_q[0] <= read0_const;
      value_q[1] <= read1_const;
    end
  end

  assign read0_const_en_held = en_q[0];
  assign read1_const_en_held = en_q[1];
  assign read0_const_held    = value_q[0];
  assign read1_const_held    = value_q[1];

endmodule

// ==== rtl/reg_tile.sv ====
// register tile with two banks
`timescale 1ns/1ps
`include "regfile_defs.svh"

module reg_tile #(
  parameter int TILE_INDEX = 0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          read_en,
  input  logic                          retire_en,
  input  logic                          init_busy,
  input  regfile_addr_pkg::row_idx_t    sweep_row,
  input  logic                          sweep_bank,
  input  regfile_addr_pkg::reg_addr_t   read0_addr,
  input  regfile_addr_pkg::reg_addr_t   read1_addr,
  input  regfile_addr_pkg::reg_addr_t   retire_addr,
  input  regfile_addr_pkg::reg_addr_t   write0_addr,
  input  regfile_data_pkg::reg_data_t   write0_data,
  input  logic                          write0_en,
  input  regfile_addr_pkg::reg_addr_t   write1_addr,
  input  regfile_data_pkg::reg_data_t   write1_data,
  input  logic                          write1_en,
  output regfile_data_pkg::reg_data_t   read0_data,
  output regfile_data_pkg::reg_data_t   read1_data,
  output regfile_data_pkg::reg_data_t   retire_data,
  output logic                          retire_hit
);

  import regfile_addr_pkg::*;
  import regfile_data_pkg::*;

  localparam int        ROWS    = 1 << `REGFILE_ROW_BITS;
  localparam tile_idx_t TILE_ID = tile_idx_t'(TILE_INDEX);

  reg_data_t bank_a [ROWS];
  reg_data_t bank_b [ROWS];

  // port 0 write path, borrowed by the sweep
  logic      wr0_en;
  row_idx_t  wr0_row;
  logic      wr0_bank;
  reg_data_t wr0_data;

  logic      wr1_en;
  row_idx_t  wr1_row;
  logic      wr1_bank;

  row_idx_t  read0_row;
  logic      read0_bank;
  logic      read0_hit;
  row_idx_t  read1_row;
  logic      read1_bank;
  logic      read1_hit;
  row_idx_t  retire_row;
  logic      retire_bank;

  assign wr0_en   = init_busy || (write0_en && addr_tile(write0_addr) == TILE_ID);
  assign wr0_row  = init_busy ? sweep_row : addr_row(write0_addr);
  assign wr0_bank = init_busy ? sweep_bank : addr_bank(write0_addr);
  assign wr0_data = init_busy ? REG_ZERO : write0_data;

  assign wr1_en   = write1_en && addr_tile(write1_addr) == TILE_ID;
  assign wr1_row  = addr_row(write1_addr);
  assign wr1_bank = addr_bank(write1_addr);

  always_ff @(posedge clk)
  begin
    if (wr0_en && !wr0_bank)
      bank_a[wr0_row] <= wr0_data;
    if (wr0_en && wr0_bank)
      bank_b[wr0_row] <= wr0_data;
    // port 1 goes last so it wins a same-address collision
    if (wr1_en && !wr1_bank)
      bank_a[wr1_row] <= write1_data;
    if (wr1_en && wr1_bank)
      bank_b[wr1_row] <= write1_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      read0_hit  <= 1'b0;
      read1_hit  <= 1'b0;
      retire_hit <= 1'b0;
    end
    else
    begin
      if (read_en)
      begin
        read0_hit <= addr_tile(read0_addr) == TILE_ID;
        read1_hit <= addr_tile(read1_addr) == TILE_ID;
      end
      if (retire_en)
        retire_hit <= addr_tile(retire_addr) == TILE_ID;
    end
  end

  always_ff @(posedge clk)
  begin
    if (read_en)
    begin
      read0_row  <= addr_row(read0_addr);
      read0_bank <= addr_bank(read0_addr);
      read1_row  <= addr_row(read1_addr);
      read1_bank <= addr_bank(read1_addr);
    end
    if (retire_en)
    begin
      retire_row  <= addr_row(retire_addr);
      retire_bank <= addr_bank(retire_addr);
    end
  end

  // reads follow the storage at the held address
  assign read0_data = {`REGFILE_DATA_WIDTH{read0_hit}} &
                      (read0_bank ? bank_b[read0_row] : bank_a[read0_row]);
  assign read1_data = {`REGFILE_DATA_WIDTH{read1_hit}} &
                      (read1_bank ? bank_b[read1_row] : bank_a[read1_row]);
  assign retire_data = retire_bank ? bank_b[retire_row] : bank_a[retire_row];

endmodule

// ==== rtl/init_sweep.sv ====
// post-reset zero sweep
`timescale 1ns/1ps
`include "regfile_defs.svh"

module init_sweep (
  input  logic                        clk,
  input  logic                        rst,
  output logic                        init_busy,
  output regfile_addr_pkg::row_idx_t  sweep_row,
  output logic                        sweep_bank
);

  import regfile_addr_pkg::*;

  localparam sweep_idx_t LAST_STEP = sweep_idx_t'(`REGFILE_SWEEP_STEPS - 1);

  sweep_idx_t step;

  // one row and bank per cycle, all tiles in parallel
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      init_busy <= 1'b1;
      step      <= '0;
    end
    else if (init_busy)
    begin
      step <= step + 1'b1;
      if (step == LAST_STEP)
        init_busy <= 1'b0;
    end
  end

  assign sweep_row  = step[4:1];
  assign sweep_bank = step[0];

endmodule

// ==== rtl/regfile_data_pkg.sv ====
// register data types
package regfile_data_pkg;

  // one stored register word
  typedef logic [31:0] reg_data_t;

  // word handed out on a read port, register or constant
  typedef logic [31:0] operand_t;

  // value written by the post-reset sweep
  localparam reg_data_t REG_ZERO = '0;

endpackage

// ==== rtl/regfile_addr_pkg.sv ====
// register address fields
package regfile_addr_pkg;

  // {row[3:0], bank, tile[1:0]}
  typedef logic [6:0] reg_addr_t;
  typedef logic [1:0] tile_idx_t;
  typedef logic [3:0] row_idx_t;

  // row in the upper bits, bank in bit 0
  typedef logic [4:0] sweep_idx_t;

  function automatic tile_idx_t addr_tile(reg_addr_t addr);
    return addr[1:0];
  endfunction

  function automatic logic addr_bank(reg_addr_t addr);
    return addr[2];
  endfunction

  function automatic row_idx_t addr_row(reg_addr_t addr);
    return addr[6:3];
  endfunction

endpackage

// ==== include/regfile_defs.svh ====
// register file sizing
`ifndef REGFILE_DEFS_SVH
`define REGFILE_DEFS_SVH

// width of one register word
`define REGFILE_DATA_WIDTH 32

// tile select sits in the low address bits
`define REGFILE_TILE_BITS 2
`define REGFILE_TILE_COUNT 4

// rows per bank, upper address bits
`define REGFILE_ROW_BITS 4

// tile, bank and row fields together
`define REGFILE_ADDR_WIDTH 7

// rows times banks, one zero write per cycle in every tile
`define REGFILE_SWEEP_STEPS 32

`endif
